/* bench/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb;

	import dcache_pkg::*;

	localparam int    NUM_BANKS   = 4;
	localparam int    INDEX_BITS  = 4;
	localparam int    MEM_WORDS   = 1024;
	localparam word_t MEM_PATTERN = 32'h5a5a_0000;

	logic  i_clock;
	logic  i_reset;
	logic  i_request;
	logic  i_rw;
	logic  i_flush;
	logic  i_cacheable;
	addr_t i_address;
	word_t i_wdata;
	logic  o_ready;
	word_t o_rdata;
	logic  o_bus_request;
	logic  o_bus_rw;
	addr_t o_bus_address;
	word_t o_bus_wdata;
	logic  i_bus_ready;
	word_t i_bus_rdata;

	// Memory behind the bus with one word per entry.
	word_t memory [MEM_WORDS];

	// Operations from the trace file.
	logic [7:0] trace_kind[$];
	logic       trace_cacheable[$];
	addr_t      trace_address[$];
	word_t      trace_wdata[$];
	word_t      trace_expected[$];

	int cycle_count = 0;
	int cycle_limit = 1000;

	dcache_top #(
		.NUM_BANKS  (NUM_BANKS),
		.INDEX_BITS (INDEX_BITS)
	) u_dut (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_flush       (i_flush),
		.i_cacheable   (i_cacheable),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// ====================================================================
	// Error handling and the compare task.
	// ====================================================================
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure("error: value mismatch");
		end
	endtask

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_with_failure($sformatf("error: timeout after %0d cycles", cycle_count));
		end
	end

	// ====================================================================
	// Trace reader.
	// ====================================================================
	// Lines starting with # are skipped up to the end of the line.
	task automatic load_trace();
		int         fd;
		int         code;
		int         ch;
		logic [7:0] kind;
		word_t      flag;
		addr_t      address;
		word_t      wdata;
		word_t      expected;
		fd = $fopen("bench/dcache_trace.txt", "r");
		if (fd == 0) begin
			stop_with_failure("error: cannot open trace file bench/dcache_trace.txt");
		end else begin
			code = $fscanf(fd, " %c", kind);
			while (code == 1) begin
				if (kind == "#") begin
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else begin
					code = $fscanf(fd, "%h %h %h %h", flag, address, wdata, expected);
					if (code != 4) begin
						stop_with_failure("error: malformed line in trace file");
					end else begin
						trace_kind.push_back(kind);
						trace_cacheable.push_back(flag[0]);
						trace_address.push_back(address);
						trace_wdata.push_back(wdata);
						trace_expected.push_back(expected);
					end
				end
				code = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
	endtask

	// One processor access held until ready.
	task automatic run_request(input logic rw, input logic flush, input logic cacheable,
			input addr_t address, input word_t wdata, output word_t rdata);
		@(posedge i_clock);
		i_request   <= 1'b1;
		i_rw        <= rw;
		i_flush     <= flush;
		i_cacheable <= cacheable;
		i_address   <= address;
		i_wdata     <= wdata;
		do begin
			@(posedge i_clock);
		end while (!o_ready);
		rdata = o_rdata;
		i_request <= 1'b0;
		i_flush   <= 1'b0;
	endtask

	// ====================================================================
	// Memory model on the bus with 0 to 3 cycles of random wait.
	// ====================================================================
	initial begin : bus_responder
		int unsigned rand_seed;
		int unsigned delay;
		logic        pending;
		rand_seed = 32'hd796_6e96;
		void'($urandom(rand_seed));
		delay     = 0;
		pending   = 1'b0;
		forever begin
			@(posedge i_clock);
			if (i_reset) begin
				i_bus_ready <= 1'b0;
				pending     = 1'b0;
			end else if (i_bus_ready) begin
				// Transfer completes on this edge.
				if (!o_bus_request) begin
					stop_with_failure("error: bus ready given but the DUT dropped its request");
				end else begin
					if (o_bus_rw) begin
						memory[o_bus_address[31:2]] = o_bus_wdata;
					end
					i_bus_ready <= 1'b0;
					pending     = 1'b0;
				end
			end else if (o_bus_request) begin
				if (o_bus_address >= MEM_WORDS * 4) begin
					stop_with_failure("error: bus address outside the memory model");
				end else begin
					if (!pending) begin
						pending = 1'b1;
						delay   = $urandom % 4;
					end
					if (delay == 0) begin
						i_bus_ready <= 1'b1;
						i_bus_rdata <= memory[o_bus_address[31:2]];
					end else begin
						delay = delay - 1;
					end
				end
			end
		end
	end

	// ====================================================================
	// Main sequence.
	// ====================================================================
	initial begin : main
		word_t rdata;
		addr_t address;
		i_reset     = 1'b1;
		i_request   = 1'b0;
		i_rw        = 1'b0;
		i_flush     = 1'b0;
		i_cacheable = 1'b0;
		i_address   = '0;
		i_wdata     = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;

		for (int i = 0; i < MEM_WORDS; i++) begin
			memory[i] = word_t'(i << 2) ^ MEM_PATTERN;
		end
		load_trace();
		cycle_limit = trace_kind.size() * 40 + 200;

		repeat (2) @(posedge i_clock);
		i_reset <= 1'b0;

		foreach (trace_kind[n]) begin
			address = trace_address[n];
			case (trace_kind[n])
				"R": begin
					run_request(1'b0, 1'b0, trace_cacheable[n], address, '0, rdata);
					check_value("o_rdata", rdata, trace_expected[n]);
				end
				"W": begin
					run_request(1'b1, 1'b0, trace_cacheable[n], address, trace_wdata[n], rdata);
				end
				"F": begin
					run_request(1'b0, 1'b1, 1'b0, address, '0, rdata);
				end
				"C": begin
					// One edge later the last bus write has landed.
					@(posedge i_clock);
					check_value($sformatf("memory[%h]", address), memory[address[31:2]],
						trace_expected[n]);
				end
				default: begin
					stop_with_failure("error: unknown operation kind in trace file");
				end
			endcase
		end

		@(posedge i_clock);
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* bench/dcache_trace.txt */
# kind cacheable address wdata expected, all hex after the kind letter
# R read, W write, F flush, C compare the memory model word at address
# Cold reads, one per bank
R 1 00000000 00000000 5a5a0000
R 1 00000004 00000000 5a5a0004
R 1 00000008 00000000 5a5a0008
R 1 0000000c 00000000 5a5a000c
# Write then read hit
W 1 00000010 11110010 00000000
R 1 00000010 00000000 11110010
# Conflict eviction on one entry
W 1 00000040 aaaa0040 00000000
W 1 00000140 bbbb0140 00000000
C 0 00000040 00000000 aaaa0040
R 1 00000040 00000000 aaaa0040
C 0 00000140 00000000 bbbb0140
# Uncacheable access
W 0 00000200 cccc0200 00000000
C 0 00000200 00000000 cccc0200
R 0 00000200 00000000 cccc0200
R 0 00000300 00000000 5a5a0300
# Writes in several banks, then flush
W 1 00000024 dddd0024 00000000
W 1 00000058 eeee0058 00000000
W 1 0000009c ffff009c 00000000
F 0 00000000 00000000 00000000
C 0 00000010 00000000 11110010
C 0 00000024 00000000 dddd0024
C 0 00000058 00000000 eeee0058
C 0 0000009c 00000000 ffff009c
# Reads after the flush
R 1 00000024 00000000 dddd0024
R 1 00000010 00000000 11110010
R 1 00000140 00000000 bbbb0140
R 1 0000009c 00000000 ffff009c

/* compile.f */
rtl/dcache_pkg.sv
rtl/dcache_line_ram.sv
rtl/dcache_bank.sv
rtl/dcache_dispatch.sv
rtl/dcache_bus_arbiter.sv
rtl/dcache_top.sv
bench/dcache_tb.sv

/* rtl/dcache_bank.sv */
`timescale 1ns/100ps

module dcache_bank #(
	parameter int INDEX_BITS = 4,
	parameter int NUM_BANKS  = 4
) (
	input  logic               i_clock,
	input  logic               i_reset,

	// Processor side, one request at a time.
	input  logic               i_request,
	input  logic               i_rw,
	input  logic               i_flush,
	input  logic               i_cacheable,
	input  dcache_pkg::addr_t  i_address,
	input  dcache_pkg::word_t  i_wdata,
	output logic               o_ready,
	output dcache_pkg::word_t  o_rdata,

	// Memory bus side, through the arbiter.
	output logic               o_bus_request,
	output logic               o_bus_rw,
	output dcache_pkg::addr_t  o_bus_address,
	output dcache_pkg::word_t  o_bus_wdata,
	input  logic               i_bus_ready,
	input  dcache_pkg::word_t  i_bus_rdata
);

	import dcache_pkg::*;

	localparam int BANK_BITS = $clog2(NUM_BANKS);
	localparam int INDEX_LSB = 2 + BANK_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [INDEX_BITS:0] count_t;

	typedef enum logic [3:0] {
		S_INITIALIZE,
		S_IDLE,
		S_FLUSH_SETUP,
		S_FLUSH_CHECK,
		S_FLUSH_WRITE,
		S_PASS_THROUGH,
		S_WRITE_SETUP,
		S_WRITE_WAIT,
		S_READ_SETUP,
		S_READ_WB_WAIT,
		S_READ_BUS_WAIT
	} state_t;

	state_t state, next_state;
	count_t flush_index, next_flush_index;

	logic   ram_write;
	index_t ram_index;
	entry_t ram_wentry;
	entry_t ram_rentry;

	index_t request_index;
	logic   entry_valid;
	logic   entry_dirty;
	addr_t  entry_address;
	word_t  entry_data;
	logic   entry_match;

	dcache_line_ram #(
		.INDEX_BITS (INDEX_BITS)
	) u_line_ram (
		.i_clock  (i_clock),
		.i_write  (ram_write),
		.i_index  (ram_index),
		.i_wentry (ram_wentry),
		.o_rentry (ram_rentry)
	);

	assign request_index = i_address[INDEX_LSB +: INDEX_BITS];
	assign entry_valid   = ram_rentry[ENTRY_VALID_BIT];
	assign entry_dirty   = ram_rentry[ENTRY_DIRTY_BIT];
	assign entry_address = {ram_rentry[31:2], 2'b00};
	assign entry_data    = ram_rentry[63:32];
	assign entry_match   = entry_valid && (ram_rentry[31:2] == i_address[31:2]);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state       <= S_INITIALIZE;
			flush_index <= '0;
		end else begin
			state       <= next_state;
			flush_index <= next_flush_index;
		end
	end

	always_comb begin
		next_state       = state;
		next_flush_index = flush_index;
		o_ready          = 1'b0;
		o_rdata          = '0;
		o_bus_request    = 1'b0;
		o_bus_rw         = 1'b0;
		o_bus_address    = '0;
		o_bus_wdata      = '0;
		ram_write        = 1'b0;
		ram_index        = request_index;
		ram_wentry       = '0;

		case (state)
			// ======================================================================
			// Clear every entry after reset.
			// ======================================================================
			S_INITIALIZE: begin
				ram_index = flush_index[INDEX_BITS-1:0];
				if (!flush_index[INDEX_BITS]) begin
					ram_write        = 1'b1;
					ram_wentry       = make_entry('0, '0, 1'b0, 1'b0);
					next_flush_index = flush_index + 1'b1;
				end else begin
					next_flush_index = '0;
					next_state       = S_IDLE;
				end
			end

			S_IDLE: begin
				if (i_request) begin
					if (i_flush) begin
						next_flush_index = '0;
						next_state       = S_FLUSH_SETUP;
					end else if (i_cacheable) begin
						next_state = i_rw ? S_WRITE_SETUP : S_READ_SETUP;
					end else begin
						o_bus_request = 1'b1;
						o_bus_rw      = i_rw;
						o_bus_address = i_address;
						o_bus_wdata   = i_wdata;
						next_state    = S_PASS_THROUGH;
					end
				end
			end

			// ======================================================================
			// Flush walks every index and writes dirty entries back.
			// ======================================================================
			S_FLUSH_SETUP: begin
				ram_index = flush_index[INDEX_BITS-1:0];
				if (!flush_index[INDEX_BITS]) begin
					next_state = S_FLUSH_CHECK;
				end else begin
					o_ready    = 1'b1;
					next_state = S_IDLE;
				end
			end

			S_FLUSH_CHECK: begin
				ram_index = flush_index[INDEX_BITS-1:0];
				if (entry_dirty) begin
					o_bus_request = 1'b1;
					o_bus_rw      = 1'b1;
					o_bus_address = entry_address;
					o_bus_wdata   = entry_data;
					next_state    = S_FLUSH_WRITE;
				end else begin
					next_flush_index = flush_index + 1'b1;
					next_state       = S_FLUSH_SETUP;
				end
			end

			S_FLUSH_WRITE: begin
				ram_index     = flush_index[INDEX_BITS-1:0];
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata   = entry_data;
				if (i_bus_ready) begin
					// Keep the entry, now clean.
					ram_write        = 1'b1;
					ram_wentry       = make_entry(entry_data, entry_address, 1'b0, 1'b1);
					next_flush_index = flush_index + 1'b1;
					next_state       = S_FLUSH_SETUP;
				end
			end

			// Uncacheable access goes straight to the bus.
			S_PASS_THROUGH: begin
				o_bus_request = i_request;
				o_bus_rw      = i_rw;
				o_bus_address = i_address;
				o_bus_wdata   = i_wdata;
				o_rdata       = i_bus_rdata;
				o_ready       = i_bus_ready;
				if (!i_request) begin
					next_state = S_IDLE;
				end
			end

			// ======================================================================
			// Write, with write-back of a dirty victim.
			// ======================================================================
			S_WRITE_SETUP: begin
				if (entry_dirty && !entry_match) begin
					o_bus_request = 1'b1;
					o_bus_rw      = 1'b1;
					o_bus_address = entry_address;
					o_bus_wdata   = entry_data;
					next_state    = S_WRITE_WAIT;
				end else begin
					ram_write  = 1'b1;
					ram_wentry = make_entry(i_wdata, i_address, 1'b1, 1'b1);
					o_ready    = 1'b1;
					next_state = S_IDLE;
				end
			end

			S_WRITE_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata   = entry_data;
				if (i_bus_ready) begin
					ram_write  = 1'b1;
					ram_wentry = make_entry(i_wdata, i_address, 1'b1, 1'b1);
					o_ready    = 1'b1;
					next_state = S_IDLE;
				end
			end

			// ======================================================================
			// Read, hit from the RAM or refill from the bus.
			// ======================================================================
			S_READ_SETUP: begin
				o_rdata = entry_data;
				if (entry_match) begin
					o_ready    = 1'b1;
					next_state = S_IDLE;
				end else if (entry_dirty) begin
					o_bus_request = 1'b1;
					o_bus_rw      = 1'b1;
					o_bus_address = entry_address;
					o_bus_wdata   = entry_data;
					next_state    = S_READ_WB_WAIT;
				end else begin
					o_bus_request = 1'b1;
					o_bus_address = i_address;
					next_state    = S_READ_BUS_WAIT;
				end
			end

			// Request stays high into the refill, so the grant is kept.
			S_READ_WB_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata   = entry_data;
				if (i_bus_ready) begin
					next_state = S_READ_BUS_WAIT;
				end
			end

			S_READ_BUS_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				o_rdata       = i_bus_rdata;
				if (i_bus_ready) begin
					ram_write  = 1'b1;
					ram_wentry = make_entry(i_bus_rdata, i_address, 1'b0, 1'b1);
					o_ready    = 1'b1;
					next_state = S_IDLE;
				end
			end

			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	// Bus stays quiet while the entries are being cleared.
	assert property (@(posedge i_clock) disable iff (i_reset)
		(state == S_INITIALIZE) |-> !o_bus_request);

	// Ready only answers a request that is still held.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> i_request);

endmodule

/* rtl/dcache_bus_arbiter.sv */
`timescale 1ns/100ps

module dcache_bus_arbiter #(
	parameter int NUM_BANKS = 4
) (
	input  logic                  i_clock,
	input  logic                  i_reset,

	input  logic [NUM_BANKS-1:0]  i_bank_bus_request,
	input  logic [NUM_BANKS-1:0]  i_bank_bus_rw,
	input  dcache_pkg::addr_t     i_bank_bus_address [NUM_BANKS],
	input  dcache_pkg::word_t     i_bank_bus_wdata [NUM_BANKS],
	output logic [NUM_BANKS-1:0]  o_bank_bus_ready,

	output logic                  o_bus_request,
	output logic                  o_bus_rw,
	output dcache_pkg::addr_t     o_bus_address,
	output dcache_pkg::word_t     o_bus_wdata,
	input  logic                  i_bus_ready
);

	localparam int GRANT_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	typedef logic [GRANT_BITS-1:0] grant_t;

	grant_t grant;
	grant_t pick;
	logic   busy;

	// Next requester after the last owner; nearest one wins.
	// The last owner itself comes last.
	always_comb begin
		pick = grant;
		for (int k = NUM_BANKS; k >= 1; k--) begin
			if (i_bank_bus_request[(grant + k) % NUM_BANKS]) begin
				pick = grant_t'((grant + k) % NUM_BANKS);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			grant <= '0;
			busy  <= 1'b0;
		end else if (!busy || !i_bank_bus_request[grant]) begin
			busy <= |i_bank_bus_request;
			if (|i_bank_bus_request) begin
				grant <= pick;
			end
		end
	end

	assign o_bus_request = busy && i_bank_bus_request[grant];
	assign o_bus_rw      = i_bank_bus_rw[grant];
	assign o_bus_address = i_bank_bus_address[grant];
	assign o_bus_wdata   = i_bank_bus_wdata[grant];

	always_comb begin
		o_bank_bus_ready        = '0;
		o_bank_bus_ready[grant] = o_bus_request && i_bus_ready;
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(o_bank_bus_ready));

endmodule

/* rtl/dcache_dispatch.sv */
`timescale 1ns/100ps

module dcache_dispatch #(
	parameter int NUM_BANKS = 4
) (
	input  logic                  i_clock,
	input  logic                  i_reset,

	input  logic                  i_request,
	input  logic                  i_flush,
	input  logic                  i_cacheable,
	input  dcache_pkg::addr_t     i_address,
	output logic                  o_ready,
	output dcache_pkg::word_t     o_rdata,

	output logic [NUM_BANKS-1:0]  o_bank_request,
	output logic [NUM_BANKS-1:0]  o_bank_flush,
	output logic [NUM_BANKS-1:0]  o_bank_cacheable,
	input  logic [NUM_BANKS-1:0]  i_bank_ready,
	input  dcache_pkg::word_t     i_bank_rdata [NUM_BANKS]
);

	import dcache_pkg::*;

	localparam int SEL_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	typedef logic [SEL_BITS-1:0] bank_sel_t;

	bank_sel_t            bank_sel;
	logic [NUM_BANKS-1:0] bank_onehot;
	logic [NUM_BANKS-1:0] flush_done;

	// Word-address bits just above the byte offset pick the bank.
	assign bank_sel = i_cacheable ? bank_sel_t'((i_address >> 2) & (NUM_BANKS - 1)) : '0;

	always_comb begin
		bank_onehot           = '0;
		bank_onehot[bank_sel] = 1'b1;
	end

	// A bank that has finished its flush is released until the request drops.
	assign o_bank_request   = {NUM_BANKS{i_request}} &
		(i_flush ? ~flush_done : bank_onehot);
	assign o_bank_flush     = {NUM_BANKS{i_flush}} & ~flush_done;
	assign o_bank_cacheable = {NUM_BANKS{i_cacheable}} & bank_onehot;

	assign o_ready = i_flush ? (i_request && (&(flush_done | i_bank_ready)))
		: i_bank_ready[bank_sel];
	assign o_rdata = i_bank_rdata[bank_sel];

	always_ff @(posedge i_clock) begin
		if (i_reset || !i_request) begin
			flush_done <= '0;
		end else if (i_flush) begin
			flush_done <= flush_done | i_bank_ready;
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		!i_flush |-> $onehot0(o_bank_request));

endmodule

/* rtl/dcache_line_ram.sv */
`timescale 1ns/100ps

module dcache_line_ram #(
	parameter int INDEX_BITS = 4
) (
	input  logic                    i_clock,
	input  logic                    i_write,
	input  logic [INDEX_BITS-1:0]   i_index,
	input  dcache_pkg::entry_t      i_wentry,
	output dcache_pkg::entry_t      o_rentry
);

	import dcache_pkg::*;

	localparam int DEPTH = 1 << INDEX_BITS;

	entry_t mem [DEPTH];

	// Read data is always one cycle behind the index.
	// A write returns the old entry in the same cycle.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wentry;
		end
		o_rentry <= mem[i_index];
	end

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

	// Byte address and data word on both the processor and the bus side.
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// Entry layout is data in [63:32], word address in [31:2], flags in [1:0].
	typedef logic [63:0] entry_t;

	localparam int ENTRY_VALID_BIT = 0;
	localparam int ENTRY_DIRTY_BIT = 1;

	// Builds one stored entry from its fields.
	function automatic entry_t make_entry(word_t data, addr_t address, logic dirty,
			logic valid);
		entry_t entry;
		entry = {data, address[31:2], 2'b00};
		entry[ENTRY_DIRTY_BIT] = dirty;
		entry[ENTRY_VALID_BIT] = valid;
		return entry;
	endfunction

endpackage

/* rtl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top #(
	parameter int NUM_BANKS  = 4,
	parameter int INDEX_BITS = 4
) (
	input  logic               i_clock,
	input  logic               i_reset,

	// Processor load/store port.
	input  logic               i_request,
	input  logic               i_rw,
	input  logic               i_flush,
	input  logic               i_cacheable,
	input  dcache_pkg::addr_t  i_address,
	input  dcache_pkg::word_t  i_wdata,
	output logic               o_ready,
	output dcache_pkg::word_t  o_rdata,

	// Shared memory bus.
	output logic               o_bus_request,
	output logic               o_bus_rw,
	output dcache_pkg::addr_t  o_bus_address,
	output dcache_pkg::word_t  o_bus_wdata,
	input  logic               i_bus_ready,
	input  dcache_pkg::word_t  i_bus_rdata
);

	import dcache_pkg::*;

	logic [NUM_BANKS-1:0] bank_request;
	logic [NUM_BANKS-1:0] bank_flush;
	logic [NUM_BANKS-1:0] bank_cacheable;
	logic [NUM_BANKS-1:0] bank_ready;
	word_t                bank_rdata [NUM_BANKS];

	logic [NUM_BANKS-1:0] bank_bus_request;
	logic [NUM_BANKS-1:0] bank_bus_rw;
	addr_t                bank_bus_address [NUM_BANKS];
	word_t                bank_bus_wdata [NUM_BANKS];
	logic [NUM_BANKS-1:0] bank_bus_ready;

	dcache_dispatch #(
		.NUM_BANKS (NUM_BANKS)
	) u_dispatch (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_request        (i_request),
		.i_flush          (i_flush),
		.i_cacheable      (i_cacheable),
		.i_address        (i_address),
		.o_ready          (o_ready),
		.o_rdata          (o_rdata),
		.o_bank_request   (bank_request),
		.o_bank_flush     (bank_flush),
		.o_bank_cacheable (bank_cacheable),
		.i_bank_ready     (bank_ready),
		.i_bank_rdata     (bank_rdata)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		dcache_bank #(
			.INDEX_BITS (INDEX_BITS),
			.NUM_BANKS  (NUM_BANKS)
		) u_bank (
			.i_clock       (i_clock),
			.i_reset       (i_reset),
			.i_request     (bank_request[b]),
			.i_rw          (i_rw),
			.i_flush       (bank_flush[b]),
			.i_cacheable   (bank_cacheable[b]),
			.i_address     (i_address),
			.i_wdata       (i_wdata),
			.o_ready       (bank_ready[b]),
			.o_rdata       (bank_rdata[b]),
			.o_bus_request (bank_bus_request[b]),
			.o_bus_rw      (bank_bus_rw[b]),
			.o_bus_address (bank_bus_address[b]),
			.o_bus_wdata   (bank_bus_wdata[b]),
			.i_bus_ready   (bank_bus_ready[b]),
			.i_bus_rdata   (i_bus_rdata)
		);
	end

	dcache_bus_arbiter #(
		.NUM_BANKS (NUM_BANKS)
	) u_bus_arbiter (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_bank_bus_request (bank_bus_request),
		.i_bank_bus_rw      (bank_bus_rw),
		.i_bank_bus_address (bank_bus_address),
		.i_bank_bus_wdata   (bank_bus_wdata),
		.o_bank_bus_ready   (bank_bus_ready),
		.o_bus_request      (o_bus_request),
		.o_bus_rw           (o_bus_rw),
		.o_bus_address      (o_bus_address),
		.o_bus_wdata        (o_bus_wdata),
		.i_bus_ready        (i_bus_ready)
	);

endmodule
